//--- rtl/miniSrc_config.svh
`ifndef MINISRC_CONFIG_SVH
`define MINISRC_CONFIG_SVH

// width of one bus word
`define WORD_WIDTH 32

// general purpose registers R0..R15
`define NUM_REGS 16

// RAM sizing, depth must match the address width
`define MEM_DEPTH      512
`define MEM_ADDR_WIDTH 9

`endif

//--- rtl/miniSrcPkg.sv
`include "miniSrc_config.svh"

package miniSrcPkg;

    typedef logic [`WORD_WIDTH-1:0]   word_t;   // one bus word
    typedef logic [2*`WORD_WIDTH-1:0] dword_t;  // full ALU result, Z contents

    // ALU opcodes, numbered as in the instruction opcode field
    typedef enum logic [4:0] {
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opAnd  = 5'b00101,
        opOr   = 5'b00110,
        opShr  = 5'b00111,
        opShra = 5'b01000,
        opShl  = 5'b01001,
        opRor  = 5'b01010,
        opRol  = 5'b01011,
        opMul  = 5'b01111,
        opDiv  = 5'b10000,
        opNeg  = 5'b10001,
        opNot  = 5'b10010
    } aluOp_e;

endpackage

//--- rtl/regGen.sv
module regGen
    import miniSrcPkg::*;
#(
    parameter type dataType = word_t    // word_t for most, dword_t for Z
) (
    input  logic    clock,
    input  logic    rst,
    input  logic    load,               // capture d at this edge
    input  dataType d,
    output dataType q
);

    // hold until load, sync clear
    always_ff @(posedge clock) begin
        if (rst) begin
            q <= '0;
        end else if (load) begin
            q <= d;
        end
    end

endmodule

//--- rtl/selectEncode.sv
`include "miniSrc_config.svh"

module selectEncode
    import miniSrcPkg::*;
(
    input  word_t                 ir,
    input  logic                  gra,          // ra field, ir[26:23]
    input  logic                  grb,          // rb field, ir[22:19]
    input  logic                  grc,          // rc field, ir[18:15]
    input  logic                  regLoadEn,
    input  logic                  regDriveEn,
    input  logic                  baDrive,      // base address mode, R0 reads zero
    output logic [`NUM_REGS-1:0]  regLoad,
    output logic [`NUM_REGS-1:0]  regDrive,
    output word_t                 cSignExt
);

    logic [$clog2(`NUM_REGS)-1:0] field;        // chosen register number
    logic                         anyGr;
    logic [`NUM_REGS-1:0]         decoded;      // one-hot of field

    assign anyGr = gra | grb | grc;

    always_comb begin
        field = '0;
        if (gra) begin
            field = ir[26:23];
        end else if (grb) begin
            field = ir[22:19];
        end else if (grc) begin
            field = ir[18:15];
        end
    end

    // no field picked means no register selected at all
    always_comb begin
        decoded = '0;
        if (anyGr) begin
            decoded[field] = 1'b1;
        end
    end

    assign regLoad  = regLoadEn ? decoded : '0;
    assign regDrive = (regDriveEn | baDrive) ? decoded : '0;

    // C field is ir[18:0], sign bit 18
    assign cSignExt = {{($bits(word_t)-19){ir[18]}}, ir[18:0]};

endmodule

//--- rtl/conFf.sv
module conFf
    import miniSrcPkg::*;
(
    input  logic  clock,
    input  logic  rst,
    input  logic  conLoad,      // latch the branch outcome
    input  word_t ir,           // C2 condition in ir[20:19]
    input  word_t bus,          // value under test
    output logic  conff
);

    logic busZero;
    logic busNeg;
    logic condMet;

    assign busZero = (bus == '0);
    assign busNeg  = bus[$bits(word_t)-1];  // sign bit

    always_comb begin
        case (ir[20:19])
            2'b00:   condMet = busZero;             // brzr
            2'b01:   condMet = !busZero;            // brnz
            2'b10:   condMet = !busNeg && !busZero; // brpl, strictly positive
            default: condMet = busNeg;              // brmi
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            conff <= 1'b0;
        end else if (conLoad) begin
            conff <= condMet;
        end
    end

endmodule

//--- rtl/alu.sv
module alu
    import miniSrcPkg::*;
(
    input  word_t  a,           // Y register
    input  word_t  b,           // bus
    input  aluOp_e op,
    input  logic   incPc,       // overrides op, gives b + 1
    output dword_t result
);

    localparam int W = $bits(word_t);

    logic [4:0]            shamt;       // shift and rotate count
    logic signed [W-1:0]   sa;
    logic signed [W-1:0]   sb;
    logic signed [2*W-1:0] product;
    logic [2*W-1:0]        rorFull;
    logic [2*W-1:0]        rolFull;
    word_t                 quotient;
    word_t                 remainder;
    word_t                 wordRes;     // result of 32-bit ops
    dword_t                wideRes;     // mul and div fill both halves
    logic                  wide;

    assign shamt = b[4:0];
    assign sa    = a;
    assign sb    = b;

    // both operands signed, extended to 64 bits before the multiply
    assign product = sa * sb;

    // rotate by shifting a doubled copy of a
    assign rorFull = {a, a} >> shamt;
    assign rolFull = {a, a} << shamt;

    // divide by zero gives zero quotient and remainder
    always_comb begin
        if (sb == '0) begin
            quotient  = '0;
            remainder = '0;
        end else begin
            quotient  = word_t'(sa / sb);   // truncates toward zero
            remainder = word_t'(sa % sb);   // takes sign of dividend
        end
    end

    always_comb begin
        wordRes = '0;
        wideRes = '0;
        wide    = 1'b0;
        case (op)
            opAdd:   wordRes = a + b;
            opSub:   wordRes = a - b;
            opAnd:   wordRes = a & b;
            opOr:    wordRes = a | b;
            opShr:   wordRes = a >> shamt;
            opShra:  wordRes = word_t'(sa >>> shamt);
            opShl:   wordRes = a << shamt;
            opRor:   wordRes = rorFull[W-1:0];
            opRol:   wordRes = rolFull[2*W-1:W];
            opMul: begin
                wide    = 1'b1;
                wideRes = product;
            end
            opDiv: begin
                wide    = 1'b1;
                wideRes = {remainder, quotient};    // HI gets remainder
            end
            opNeg:   wordRes = -b;
            opNot:   wordRes = ~b;
            default: wordRes = '0;                  // unused codes
        endcase
        if (incPc) begin
            wide    = 1'b0;
            wordRes = b + 1'b1;
        end
    end

    // word results sit in the low half
    assign result = wide ? wideRes : {{W{1'b0}}, wordRes};

endmodule

//--- rtl/datapath.sv
`include "miniSrc_config.svh"

module datapath
    import miniSrcPkg::*;
(
    input  logic                 clock,
    input  logic                 rst,
    input  word_t                inPortData,    // external input pins
    input  word_t                pcValue,       // from PC
    input  word_t                mdrValue,      // from MDR
    input  word_t                cSignExt,      // immediate from IR
    input  logic [`NUM_REGS-1:0] regLoad,       // one-hot from selectEncode
    input  logic [`NUM_REGS-1:0] regDrive,
    input  logic                 baDrive,
    input  logic                 jalR15,        // link register load
    input  logic                 yLoad,
    input  logic                 hiLoad,
    input  logic                 hiDrive,
    input  logic                 loLoad,
    input  logic                 loDrive,
    input  logic                 zLoad,
    input  logic                 zHighDrive,
    input  logic                 zLowDrive,
    input  logic                 pcDrive,
    input  logic                 mdrDrive,
    input  logic                 inPortLoad,
    input  logic                 inPortDrive,
    input  logic                 outPortLoad,
    input  logic                 cDrive,
    input  logic                 incPc,
    input  aluOp_e               opcode,
    output word_t                bus,           // shared bus, also to PC/IR/MAR/MDR
    output word_t                outPortData
);

    localparam int W = $bits(word_t);

    word_t                regQ [`NUM_REGS];     // R0..R15 contents
    logic [`NUM_REGS-1:0] regLoadAll;
    word_t                regBusVal;            // selected register for the bus
    word_t                hiQ;
    word_t                loQ;
    word_t                yQ;
    word_t                inPortQ;
    dword_t               zQ;
    dword_t               aluResult;

    // jal writes R15 whatever the field selects say
    assign regLoadAll = regLoad | {jalR15, {(`NUM_REGS-1){1'b0}}};

    for (genvar i = 0; i < `NUM_REGS; i++) begin : genRegs
        regGen #(.dataType(word_t)) gpReg (
            .clock (clock),
            .rst   (rst),
            .load  (regLoadAll[i]),
            .d     (bus),
            .q     (regQ[i])
        );
    end

    regGen #(.dataType(word_t)) hiReg (
        .clock (clock),
        .rst   (rst),
        .load  (hiLoad),
        .d     (bus),
        .q     (hiQ)
    );

    regGen #(.dataType(word_t)) loReg (
        .clock (clock),
        .rst   (rst),
        .load  (loLoad),
        .d     (bus),
        .q     (loQ)
    );

    regGen #(.dataType(word_t)) yReg (      // ALU a operand
        .clock (clock),
        .rst   (rst),
        .load  (yLoad),
        .d     (bus),
        .q     (yQ)
    );

    regGen #(.dataType(dword_t)) zReg (     // full 64-bit ALU result
        .clock (clock),
        .rst   (rst),
        .load  (zLoad),
        .d     (aluResult),
        .q     (zQ)
    );

    regGen #(.dataType(word_t)) inPortReg (
        .clock (clock),
        .rst   (rst),
        .load  (inPortLoad),
        .d     (inPortData),
        .q     (inPortQ)
    );

    regGen #(.dataType(word_t)) outPortReg (
        .clock (clock),
        .rst   (rst),
        .load  (outPortLoad),
        .d     (bus),
        .q     (outPortData)
    );

    alu aluInst (
        .a      (yQ),
        .b      (bus),
        .op     (opcode),
        .incPc  (incPc),
        .result (aluResult)
    );

    // register read mux, lowest index wins on overlap
    always_comb begin
        regBusVal = '0;
        for (int i = `NUM_REGS - 1; i >= 0; i--) begin
            if (regDrive[i]) begin
                regBusVal = regQ[i];
            end
        end
        if (baDrive && regDrive[0]) begin
            regBusVal = '0;     // base address mode, R0 as zero
        end
    end

    // fixed priority bus mux, zero when idle
    always_comb begin
        if (|regDrive) begin
            bus = regBusVal;
        end else if (hiDrive) begin
            bus = hiQ;
        end else if (loDrive) begin
            bus = loQ;
        end else if (zHighDrive) begin
            bus = zQ[2*W-1:W];
        end else if (zLowDrive) begin
            bus = zQ[W-1:0];
        end else if (pcDrive) begin
            bus = pcValue;
        end else if (mdrDrive) begin
            bus = mdrValue;
        end else if (inPortDrive) begin
            bus = inPortQ;
        end else if (cDrive) begin
            bus = cSignExt;
        end else begin
            bus = '0;
        end
    end

endmodule

//--- rtl/memIf.sv
`include "miniSrc_config.svh"

module memIf (
    input  logic                   clock,
    input  logic                   rst,
    input  logic                   marLoad,
    input  logic                   mdrLoad,
    input  logic                   memRead,     // MDR takes RAM data instead of bus
    input  logic                   memWrite,    // MDR into RAM[MAR] at the edge
    input  logic [`WORD_WIDTH-1:0] bus,
    output logic [`WORD_WIDTH-1:0] mdrValue
);

    logic [`WORD_WIDTH-1:0]    marQ;
    logic [`WORD_WIDTH-1:0]    mdrIn;           // MDR input mux
    logic [`WORD_WIDTH-1:0]    ramData;
    logic [`MEM_ADDR_WIDTH-1:0] addr;
    logic [`WORD_WIDTH-1:0]    ram [`MEM_DEPTH];

    regGen #(.dataType(logic [`WORD_WIDTH-1:0])) marReg (
        .clock (clock),
        .rst   (rst),
        .load  (marLoad),
        .d     (bus),
        .q     (marQ)
    );

    regGen #(.dataType(logic [`WORD_WIDTH-1:0])) mdrReg (
        .clock (clock),
        .rst   (rst),
        .load  (mdrLoad),
        .d     (mdrIn),
        .q     (mdrValue)
    );

    assign addr    = marQ[`MEM_ADDR_WIDTH-1:0];   // upper MAR bits ignored
    assign ramData = ram[addr];                   // async read
    assign mdrIn   = memRead ? ramData : bus;

    always_ff @(posedge clock) begin
        if (memWrite) begin
            ram[addr] <= mdrValue;
        end
    end

endmodule

//--- rtl/miniSrc.sv
`include "miniSrc_config.svh"

module miniSrc
    import miniSrcPkg::*;
(
    input  logic   clock,
    input  logic   rst,
    input  word_t  inPortData,
    output word_t  outPortData,
    output logic   conff,           // branch taken flag
    input  logic   conLoad,
    input  logic   gra,             // IR field selects
    input  logic   grb,
    input  logic   grc,
    input  logic   regLoadEn,
    input  logic   regDriveEn,
    input  logic   baDrive,
    input  logic   pcDrive,         // PC and IR
    input  logic   incPc,
    input  logic   pcLoad,
    input  logic   irLoad,
    input  logic   yLoad,           // datapath registers
    input  logic   hiDrive,
    input  logic   hiLoad,
    input  logic   loDrive,
    input  logic   loLoad,
    input  logic   cDrive,
    input  logic   zHighDrive,
    input  logic   zLowDrive,
    input  logic   zLoad,
    input  logic   mdrDrive,        // memory side
    input  logic   mdrLoad,
    input  logic   marLoad,
    input  logic   memRead,
    input  logic   memWrite,
    input  logic   inPortLoad,      // ports
    input  logic   outPortLoad,
    input  logic   inPortDrive,
    input  logic   jalR15,
    input  aluOp_e opcode
);

    word_t                bus;
    word_t                pcValue;
    word_t                irValue;
    word_t                mdrValue;
    word_t                cSignExt;
    logic [`NUM_REGS-1:0] regLoad;
    logic [`NUM_REGS-1:0] regDrive;

    regGen #(.dataType(word_t)) pcReg (
        .clock (clock),
        .rst   (rst),
        .load  (pcLoad),
        .d     (bus),
        .q     (pcValue)
    );

    regGen #(.dataType(word_t)) irReg (
        .clock (clock),
        .rst   (rst),
        .load  (irLoad),
        .d     (bus),
        .q     (irValue)
    );

    selectEncode selEnc (
        .ir         (irValue),
        .gra        (gra),
        .grb        (grb),
        .grc        (grc),
        .regLoadEn  (regLoadEn),
        .regDriveEn (regDriveEn),
        .baDrive    (baDrive),
        .regLoad    (regLoad),
        .regDrive   (regDrive),
        .cSignExt   (cSignExt)
    );

    conFf branchCond (
        .clock   (clock),
        .rst     (rst),
        .conLoad (conLoad),
        .ir      (irValue),
        .bus     (bus),
        .conff   (conff)
    );

    memIf memory (
        .clock    (clock),
        .rst      (rst),
        .marLoad  (marLoad),
        .mdrLoad  (mdrLoad),
        .memRead  (memRead),
        .memWrite (memWrite),
        .bus      (bus),
        .mdrValue (mdrValue)
    );

    datapath dp (
        .clock       (clock),
        .rst         (rst),
        .inPortData  (inPortData),
        .pcValue     (pcValue),
        .mdrValue    (mdrValue),
        .cSignExt    (cSignExt),
        .regLoad     (regLoad),
        .regDrive    (regDrive),
        .baDrive     (baDrive),
        .jalR15      (jalR15),
        .yLoad       (yLoad),
        .hiLoad      (hiLoad),
        .hiDrive     (hiDrive),
        .loLoad      (loLoad),
        .loDrive     (loDrive),
        .zLoad       (zLoad),
        .zHighDrive  (zHighDrive),
        .zLowDrive   (zLowDrive),
        .pcDrive     (pcDrive),
        .mdrDrive    (mdrDrive),
        .inPortLoad  (inPortLoad),
        .inPortDrive (inPortDrive),
        .outPortLoad (outPortLoad),
        .cDrive      (cDrive),
        .incPc       (incPc),
        .opcode      (opcode),
        .bus         (bus),
        .outPortData (outPortData)
    );

endmodule

//--- tb/miniSrc_sva.sv
`include "miniSrc_config.svh"

module miniSrcSva
    import miniSrcPkg::*;
(
    input logic                 clock,
    input logic                 rst,
    input logic [`NUM_REGS-1:0] regLoad,
    input logic [`NUM_REGS-1:0] regDrive,
    input logic                 hiDrive,
    input logic                 loDrive,
    input logic                 zHighDrive,
    input logic                 zLowDrive,
    input logic                 pcDrive,
    input logic                 mdrDrive,
    input logic                 inPortDrive,
    input logic                 cDrive,
    input word_t                outPortData
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [8:0] drivers;    // one bit per bus source

    assign drivers = {|regDrive, hiDrive, loDrive, zHighDrive, zLowDrive,
                      pcDrive, mdrDrive, inPortDrive, cDrive};

    // at most one source on the bus
    busSingleDriver: assert property (@(posedge clock) disable iff (rst)
        $onehot0(drivers))
        else $error("bus has more than one driver, drivers %b", drivers);

    // field load and jal never hit two registers at once
    regLoadSingle: assert property (@(posedge clock) disable iff (rst)
        $onehot0(regLoad))
        else $error("more than one general register loading, regLoad %h", regLoad);

    // output port cleared by reset
    outPortCleared: assert property (@(posedge clock)
        rst |=> (outPortData == '0))
        else $error("output port not zero after reset, outPortData %h", outPortData);

endmodule

bind datapath miniSrcSva dpChecks (
    .clock       (clock),
    .rst         (rst),
    .regLoad     (regLoadAll),      // field loads merged with jal
    .regDrive    (regDrive),
    .hiDrive     (hiDrive),
    .loDrive     (loDrive),
    .zHighDrive  (zHighDrive),
    .zLowDrive   (zLowDrive),
    .pcDrive     (pcDrive),
    .mdrDrive    (mdrDrive),
    .inPortDrive (inPortDrive),
    .cDrive      (cDrive),
    .outPortData (outPortData)
);

//--- tb/miniSrcTb.sv
module miniSrcTb
    import miniSrcPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NS        = 29;      // number of strobes
    localparam int maxCycles = 2000;    // tests take about 600

    // one-bit masks into the strobe vector
    localparam logic [NS-1:0] mConLoad     = NS'(1) << 0;
    localparam logic [NS-1:0] mGra         = NS'(1) << 1;
    localparam logic [NS-1:0] mGrb         = NS'(1) << 2;
    localparam logic [NS-1:0] mGrc         = NS'(1) << 3;
    localparam logic [NS-1:0] mRegLoadEn   = NS'(1) << 4;
    localparam logic [NS-1:0] mRegDriveEn  = NS'(1) << 5;
    localparam logic [NS-1:0] mBaDrive     = NS'(1) << 6;
    localparam logic [NS-1:0] mPcDrive     = NS'(1) << 7;
    localparam logic [NS-1:0] mIncPc       = NS'(1) << 8;
    localparam logic [NS-1:0] mPcLoad      = NS'(1) << 9;
    localparam logic [NS-1:0] mIrLoad      = NS'(1) << 10;
    localparam logic [NS-1:0] mYLoad       = NS'(1) << 11;
    localparam logic [NS-1:0] mHiDrive     = NS'(1) << 12;
    localparam logic [NS-1:0] mHiLoad      = NS'(1) << 13;
    localparam logic [NS-1:0] mLoDrive     = NS'(1) << 14;
    localparam logic [NS-1:0] mLoLoad      = NS'(1) << 15;
    localparam logic [NS-1:0] mCDrive      = NS'(1) << 16;
    localparam logic [NS-1:0] mZHighDrive  = NS'(1) << 17;
    localparam logic [NS-1:0] mZLowDrive   = NS'(1) << 18;
    localparam logic [NS-1:0] mZLoad       = NS'(1) << 19;
    localparam logic [NS-1:0] mMdrDrive    = NS'(1) << 20;
    localparam logic [NS-1:0] mMdrLoad     = NS'(1) << 21;
    localparam logic [NS-1:0] mMarLoad     = NS'(1) << 22;
    localparam logic [NS-1:0] mMemRead     = NS'(1) << 23;
    localparam logic [NS-1:0] mMemWrite    = NS'(1) << 24;
    localparam logic [NS-1:0] mInPortLoad  = NS'(1) << 25;
    localparam logic [NS-1:0] mOutPortLoad = NS'(1) << 26;
    localparam logic [NS-1:0] mInPortDrive = NS'(1) << 27;
    localparam logic [NS-1:0] mJalR15      = NS'(1) << 28;

    logic    clock;
    logic    rst;
    word_t   inPortData;
    word_t   outPortData;
    logic    conff;
    aluOp_e  opcode;
    logic [NS-1:0] strobes;     // all control lines of the DUT
    logic    conLoad, gra, grb, grc, regLoadEn, regDriveEn, baDrive;
    logic    pcDrive, incPc, pcLoad, irLoad, yLoad, hiDrive, hiLoad, loDrive, loLoad;
    logic    cDrive, zHighDrive, zLowDrive, zLoad, mdrDrive, mdrLoad, marLoad;
    logic    memRead, memWrite, inPortLoad, outPortLoad, inPortDrive, jalR15;
    int      errors = 0;
    int      cycles = 0;

    assign {jalR15, inPortDrive, outPortLoad, inPortLoad, memWrite, memRead,
            marLoad, mdrLoad, mdrDrive, zLoad, zLowDrive, zHighDrive, cDrive,
            loLoad, loDrive, hiLoad, hiDrive, yLoad, irLoad, pcLoad, incPc,
            pcDrive, baDrive, regDriveEn, regLoadEn, grc, grb, gra, conLoad} = strobes;

    miniSrc DUT (.*);

    initial clock = 1'b0;
    always #5 clock = ~clock;

    // run limit
    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= maxCycles) begin
            $display("Timeout: tests did not finish within %0d cycles", maxCycles);
            $display("Testbench failed");
            $finish;
        end
    end

    // one register transfer, strobes held until the next edge
    task automatic transfer(input logic [NS-1:0] s, input aluOp_e op = opAdd);
        @(posedge clock);
        strobes <= s;
        opcode  <= op;
    endtask

    task automatic idle();
        transfer('0);
    endtask

    // word enters through the input port, then goes from the bus to dst
    task automatic putIn(input word_t v, input logic [NS-1:0] dst);
        transfer(mInPortLoad);
        inPortData <= v;
        transfer(mInPortDrive | dst);
    endtask

    task automatic setIr(input word_t v);
        putIn(v, mIrLoad);
    endtask

    // source onto the bus, into the output port, sampled mid-cycle
    task automatic toOut(input logic [NS-1:0] src, output word_t val);
        transfer(src | mOutPortLoad);
        idle();
        @(negedge clock);
        val = outPortData;
    endtask

    task automatic checkWord(input string sig, input string ctx, input word_t exp,
                             input word_t act);
        assert (act === exp) else begin
            errors++;
            $display("ERROR %s: expected 0x%h, got 0x%h (%s)", sig, exp, act, ctx);
        end
    endtask

    function automatic word_t irWithFields(logic [3:0] ra, logic [3:0] rb, logic [3:0] rc);
        return {5'b0, ra, rb, rc, 15'b0};
    endfunction

    // expected word ALU result, count from b[4:0]
    function automatic word_t expectedWordOp(aluOp_e op, word_t a, word_t b);
        int unsigned n;
        n = b[4:0];
        case (op)
            opAdd:   return a + b;
            opSub:   return a + ~b + 32'd1;    // two's complement
            opAnd:   return a & b;
            opOr:    return a | b;
            opShr:   return a >> n;
            opShra:  return word_t'($signed(a) >>> n);
            opShl:   return a << n;
            opRor:   return (n == 0) ? a : ((a >> n) | (a << (32 - n)));
            opRol:   return (n == 0) ? a : ((a << n) | (a >> (32 - n)));
            opNeg:   return 32'd0 - b;
            opNot:   return b ^ 32'hffff_ffff;
            default: return '0;
        endcase
    endfunction

    function automatic dword_t expectedMul(word_t a, word_t b);
        int     sa;
        int     sb;
        longint p;
        sa = a;
        sb = b;
        p  = longint'(sa) * longint'(sb);  // signed 64-bit product
        return dword_t'(p);
    endfunction

    // remainder in the high half, zero divisor gives zero
    function automatic dword_t expectedDiv(word_t a, word_t b);
        int sa;
        int sb;
        int q;
        int r;
        sa = a;
        sb = b;
        if (sb == 0) begin
            return '0;
        end
        q = sa / sb;
        r = sa - q * sb;
        return {word_t'(r), word_t'(q)};
    endfunction

    task automatic testRegMoves();
        word_t      w;
        word_t      got;
        logic [3:0] ra;
        logic [3:0] rb;
        for (int t = 0; t < 3; t++) begin
            w  = $urandom;
            ra = 4'($urandom % 15 + 1);
            rb = ra ^ 4'($urandom % 15 + 1);    // always differs from ra
            setIr(irWithFields(ra, rb, 4'h0));
            putIn(w, mGra | mRegLoadEn);
            transfer(mGra | mRegDriveEn | mHiLoad);     // ra to HI
            transfer(mHiDrive | mGrb | mRegLoadEn);     // HI to rb
            toOut(mGrb | mRegDriveEn, got);
            checkWord("outPortData", "register move", w, got);
        end
    endtask

    task automatic testAluOps();
        aluOp_e ops [11] = '{opAdd, opSub, opAnd, opOr, opShr, opShra, opShl,
                             opRor, opRol, opNeg, opNot};
        word_t  a;
        word_t  b;
        word_t  got;
        setIr(irWithFields(4'd2, 4'd0, 4'd0));   // b operand in R2
        foreach (ops[i]) begin
            for (int k = 0; k < 3; k++) begin
                a = $urandom;
                b = $urandom;
                if (k == 1) b[4:0] = 5'd0;       // zero shift count
                if (k == 2) b[4:0] = 5'd31;      // largest count
                putIn(a, mYLoad);
                putIn(b, mGra | mRegLoadEn);
                transfer(mGra | mRegDriveEn | mZLoad, ops[i]);
                toOut(mZLowDrive, got);
                checkWord("zLow", ops[i].name(), expectedWordOp(ops[i], a, b), got);
                toOut(mZHighDrive, got);
                checkWord("zHigh", ops[i].name(), '0, got);
            end
        end
        // PC increment through Z and back
        a = $urandom;
        putIn(a, mPcLoad);
        transfer(mPcDrive | mIncPc | mZLoad);
        transfer(mZLowDrive | mPcLoad);
        toOut(mPcDrive, got);
        checkWord("pc", "incPc", a + 32'd1, got);
        // R0 holds a nonzero word, baDrive must still read zero
        setIr(irWithFields(4'd0, 4'd0, 4'd0));
        b = $urandom | 32'd1;
        putIn(b, mGra | mRegLoadEn);
        a = $urandom;
        putIn(a, mYLoad);
        transfer(mGra | mBaDrive | mZLoad, opAdd);
        toOut(mZLowDrive, got);
        checkWord("zLow", "baDrive on R0", a, got);
        transfer(mGra | mRegDriveEn | mZLoad, opAdd);
        toOut(mZLowDrive, got);
        checkWord("zLow", "plain R0 drive", a + b, got);
    endtask

    task automatic mulDivCase(input aluOp_e op, input word_t a, input word_t b);
        dword_t exp;
        word_t  got;
        exp = (op == opMul) ? expectedMul(a, b) : expectedDiv(a, b);
        putIn(a, mYLoad);
        putIn(b, mGra | mRegLoadEn);
        transfer(mGra | mRegDriveEn | mZLoad, op);
        transfer(mZHighDrive | mHiLoad);
        transfer(mZLowDrive | mLoLoad);
        toOut(mHiDrive, got);
        checkWord("hi", op.name(), exp[63:32], got);
        toOut(mLoDrive, got);
        checkWord("lo", op.name(), exp[31:0], got);
    endtask

    task automatic testMulDiv();
        word_t a;
        word_t b;
        setIr(irWithFields(4'd3, 4'd0, 4'd0));
        for (int t = 0; t < 5; t++) begin
            a = $urandom;
            b = word_t'($signed($urandom) >>> ($urandom % 28));  // mixed magnitudes
            if (t == 4) b = '0;                                   // divide by zero
            mulDivCase(opMul, a, b);
            mulDivCase(opDiv, a, b);
        end
    endtask

    task automatic memWriteWord(input word_t addr, input word_t data);
        putIn(addr, mMarLoad);
        putIn(data, mMdrLoad);
        transfer(mMemWrite);
        putIn(~data, mMdrLoad);     // stale MDR, read must come from RAM
    endtask

    task automatic memReadWord(input word_t addr, output word_t data);
        putIn(addr, mMarLoad);
        transfer(mMemRead | mMdrLoad);
        toOut(mMdrDrive, data);
    endtask

    task automatic testMemory();
        word_t addr1;
        word_t addr2;
        word_t d1;
        word_t d2;
        word_t got;
        addr1 = $urandom;                   // upper bits past MAR range too
        addr2 = addr1 ^ 32'h0000_0155;      // another RAM word
        d1    = $urandom;
        d2    = $urandom;
        memWriteWord(addr1, d1);
        memWriteWord(addr2, d2);
        memReadWord(addr1, got);
        checkWord("outPortData", "first address", d1, got);
        memReadWord(addr2, got);
        checkWord("outPortData", "second address", d2, got);
    endtask

    task automatic testBranch();
        word_t vals [3];
        logic  exp;
        for (int c = 0; c < 4; c++) begin
            setIr({11'b0, 2'(c), 19'b0});   // C2 in ir[20:19]
            vals[0] = '0;
            vals[1] = ($urandom & 32'h7fff_ffff) | 32'd1;
            vals[2] = $urandom | 32'h8000_0000;
            foreach (vals[k]) begin
                case (c)
                    0:       exp = (vals[k] == 0);
                    1:       exp = (vals[k] != 0);
                    2:       exp = ($signed(vals[k]) > 0);
                    default: exp = ($signed(vals[k]) < 0);
                endcase
                putIn(vals[k], mConLoad);
                idle();
                @(negedge clock);
                checkWord("conff", $sformatf("code %0d value %h", c, vals[k]),
                          {31'b0, exp}, {31'b0, conff});
            end
        end
    endtask

    task automatic testFieldDecode();
        word_t v4;
        word_t v5;
        word_t v6;
        word_t got;
        word_t ir;
        v4 = $urandom;
        v5 = $urandom;
        v6 = $urandom;
        setIr(irWithFields(4'd4, 4'd5, 4'd6));
        putIn(v4, mGra | mRegLoadEn);
        putIn(v5, mGrb | mRegLoadEn);
        putIn(v6, mGrc | mRegLoadEn);
        // fields rotated, each register read through a different select
        setIr(irWithFields(4'd6, 4'd4, 4'd5));
        toOut(mGra | mRegDriveEn, got);
        checkWord("outPortData", "R6 via gra", v6, got);
        toOut(mGrb | mRegDriveEn, got);
        checkWord("outPortData", "R4 via grb", v4, got);
        toOut(mGrc | mRegDriveEn, got);
        checkWord("outPortData", "R5 via grc", v5, got);
        v4 = $urandom;
        putIn(v4, mJalR15);                 // link register, no field select
        setIr(irWithFields(4'd15, 4'd0, 4'd0));
        toOut(mGra | mRegDriveEn, got);
        checkWord("outPortData", "R15 after jal", v4, got);
        for (int s = 0; s < 2; s++) begin
            ir     = $urandom;
            ir[18] = s[0];                  // sign of the constant
            setIr(ir);
            toOut(mCDrive, got);
            checkWord("outPortData", "cSignExt",
                      ir[18] ? {13'h1fff, ir[18:0]} : {13'h0000, ir[18:0]}, got);
        end
    endtask

    initial begin
        void'($urandom(32'h12da));
        rst        = 1'b1;
        strobes    = '0;
        opcode     = opAdd;
        inPortData = '0;
        repeat (3) @(posedge clock);
        rst <= 1'b0;
        @(negedge clock);
        checkWord("conff", "after reset", '0, {31'b0, conff});
        checkWord("outPortData", "after reset", '0, outPortData);
        testRegMoves();
        testAluOps();
        testMulDiv();
        testMemory();
        testBranch();
        testFieldDecode();
        idle();
        $display("Run finished after %0d cycles with %0d errors", cycles, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+rtl
rtl/miniSrcPkg.sv
rtl/regGen.sv
rtl/selectEncode.sv
rtl/conFf.sv
rtl/alu.sv
rtl/datapath.sv
rtl/memIf.sv
rtl/miniSrc.sv
tb/miniSrc_sva.sv
tb/miniSrcTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f compile.f --top-module miniSrcTb -o miniSrcSim

output=$(./obj_dir/miniSrcSim 2>&1) || true
echo "$output"

if grep -q "Testbench passed" <<< "$output"; then
    exit 0
else
    exit 1
fi
